//--- hdl/spiRegsPkg.sv
// Shared widths, types and register map of the serial GPIO slave, referenced as spiRegsPkg::name
package spiRegsPkg;

  // --------------------------------------------------------------------------
  // Frame layout
  // --------------------------------------------------------------------------

  // SCK rising edges per frame, address byte then data byte
  localparam int frameBits = 16;
  localparam int addrBits = 8;
  localparam int dataBits = 8;
  // Low address bits that select a register
  localparam int idxBits = 6;
  // Read flag is the first bit sent
  localparam int readFlagBit = 7;

  typedef logic [dataBits-1:0] byteT;
  typedef logic [idxBits-1:0] regIdxT;
  typedef logic [$clog2(frameBits)-1:0] bitCountT;

  // Counter values that mark the frame phases
  localparam bitCountT addrLastCount = bitCountT'(addrBits - 1);
  localparam bitCountT dataFirstCount = bitCountT'(addrBits);
  localparam bitCountT frameLastCount = bitCountT'(frameBits - 1);

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------
  localparam regIdxT regOutData = 6'd0;
  localparam regIdxT regDir = 6'd1;
  localparam regIdxT regPinIn = 6'd2;
  localparam regIdxT regRiseFlags = 6'd3;
  localparam regIdxT regScratchFirst = 6'd4;
  localparam regIdxT regScratchLast = 6'd7;

  localparam int scratchCount = regScratchLast - regScratchFirst + 1;
  typedef logic [$clog2(scratchCount)-1:0] scratchSelT;

endpackage

//--- hdl/regAccessIf.sv
// Register access bus from the serial frame decoder to the register bank, one per slave
`timescale 1ns/100ps

interface regAccessIf;

  // Register index from the address byte
  // Valid from edge 8 of the frame
  spiRegsPkg::regIdxT addr;
  // Single-cycle write strobe
  logic wrEn;
  spiRegsPkg::byteT wrData;
  // Combinational readback of addr
  spiRegsPkg::byteT rdData;

  modport decoder (
    output addr,
    output wrEn,
    output wrData,
    input  rdData
  );

  modport bank (
    input  addr,
    input  wrEn,
    input  wrData,
    output rdData
  );

endinterface

//--- hdl/gpioCtrlIf.sv
// Control and status link between the register bank and the GPIO port block
`timescale 1ns/100ps

interface gpioCtrlIf;

  // Output latch and direction, 1 means drive
  spiRegsPkg::byteT outData;
  spiRegsPkg::byteT dirData;
  // One-cycle pulse with the written byte on a flag write
  // Zero at all other times
  spiRegsPkg::byteT clearMask;
  // Sampled pins and sticky rise flags back to the bank
  spiRegsPkg::byteT pinIn;
  spiRegsPkg::byteT riseFlags;

  modport bank (
    output outData,
    output dirData,
    output clearMask,
    input  pinIn,
    input  riseFlags
  );

  modport port (
    input  outData,
    input  dirData,
    input  clearMask,
    output pinIn,
    output riseFlags
  );

endinterface

//--- hdl/spiFrameDecoder.sv
// Serial frame decoder; turns 16-bit SCK frames into register reads on SO and write strobes
`timescale 1ns/100ps

module spiFrameDecoder (
  input  logic SCK,
  input  logic CS,
  input  logic SI,
  output logic SO,
  output logic soEnable,
  regAccessIf.decoder bus
);

  // --------------------------------------------------------------------------
  // Declarations
  // --------------------------------------------------------------------------

  // Position within the frame, 0 before edge 1
  spiRegsPkg::bitCountT bitCount;
  // Read flag of the current frame
  logic readFlag;
  logic wrEnReg;

  // Address shifter and its next value
  logic [spiRegsPkg::addrBits-1:0] addrShift;
  logic [spiRegsPkg::addrBits-1:0] addrNext;
  // Data shifter, write data in or read data out
  spiRegsPkg::byteT dataReg;

  // Phase decodes
  logic addrPhase;
  logic addrLast;
  logic dataFirst;
  logic frameLast;

  // --------------------------------------------------------------------------
  // Phase decode
  // --------------------------------------------------------------------------

  // Edges 1 to 8 carry the address byte
  assign addrPhase = (bitCount <= spiRegsPkg::addrLastCount);
  // Edge 8
  assign addrLast = (bitCount == spiRegsPkg::addrLastCount);
  // Edge 9
  assign dataFirst = (bitCount == spiRegsPkg::dataFirstCount);
  // Edge 16
  assign frameLast = (bitCount == spiRegsPkg::frameLastCount);

  // MSB first, new bit enters at the bottom
  assign addrNext = {addrShift[spiRegsPkg::addrBits-2:0], SI};

  // --------------------------------------------------------------------------
  // Bit counter
  // --------------------------------------------------------------------------

  // Wraps after edge 16 so frames can stream back to back
  always_ff @(posedge SCK or negedge CS) begin
    if (!CS) begin
      bitCount <= '0;
    end else if (frameLast) begin
      bitCount <= '0;
    end else begin
      bitCount <= bitCount + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Read flag, SO enable and write strobe
  // --------------------------------------------------------------------------

  always_ff @(posedge SCK or negedge CS) begin
    if (!CS) begin
      readFlag <= 1'b0;
      soEnable <= 1'b0;
      wrEnReg <= 1'b0;
    end else begin
      // Flag decided per frame, so reads and writes can alternate
      if (addrLast) begin
        readFlag <= addrNext[spiRegsPkg::readFlagBit];
      end
      // SO driven through the data half of a read frame only
      if (addrLast) begin
        soEnable <= addrNext[spiRegsPkg::readFlagBit];
      end else if (frameLast) begin
        soEnable <= 1'b0;
      end
      // High for the cycle after edge 16, bank commits on edge 17
      wrEnReg <= frameLast && !readFlag;
    end
  end

  // --------------------------------------------------------------------------
  // Address and data shifters
  // --------------------------------------------------------------------------

  always_ff @(posedge SCK) begin
    if (addrPhase) begin
      addrShift <= addrNext;
    end
    // Read data loaded on edge 9, then moved up one bit per edge
    if (dataFirst && readFlag) begin
      dataReg <= bus.rdData;
    end else if (!addrPhase) begin
      dataReg <= {dataReg[spiRegsPkg::dataBits-2:0], SI};
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------

  // MSB of the shifter goes out first
  assign SO = dataReg[spiRegsPkg::dataBits-1];

  // Bit 6 of the address byte is ignored
  assign bus.addr = addrShift[spiRegsPkg::idxBits-1:0];
  // Address holds through edge 17 since shifting restarts on that edge
  assign bus.wrData = dataReg;
  assign bus.wrEn = wrEnReg;

endmodule

//--- hdl/regBank.sv
// Register bank of the serial GPIO slave; stores host registers and muxes readback by index
`timescale 1ns/100ps

module regBank (
  input  logic SCK,
  regAccessIf.bank bus,
  gpioCtrlIf.bank gpio
);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // Undefined until first written by the host
  spiRegsPkg::byteT outReg;
  spiRegsPkg::byteT dirReg;
  spiRegsPkg::byteT scratch [spiRegsPkg::scratchCount];

  // Scratch slot selected by the current index
  spiRegsPkg::regIdxT scratchOfs;
  spiRegsPkg::scratchSelT scratchSel;

  assign scratchOfs = bus.addr - spiRegsPkg::regScratchFirst;
  assign scratchSel = spiRegsPkg::scratchSelT'(scratchOfs);

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  // Commit on the edge where wrEn is seen high
  always_ff @(posedge SCK) begin
    if (bus.wrEn) begin
      case (bus.addr) inside
        spiRegsPkg::regOutData: begin
          outReg <= bus.wrData;
        end
        spiRegsPkg::regDir: begin
          dirReg <= bus.wrData;
        end
        [spiRegsPkg::regScratchFirst:spiRegsPkg::regScratchLast]: begin
          scratch[scratchSel] <= bus.wrData;
        end
        // Pin readback is read only
        // Flag clears go out through clearMask
        default: begin
        end
      endcase
    end
  end

  // Write-one-to-clear strobe toward the port block
  // Lasts exactly as long as wrEn
  assign gpio.clearMask = (bus.wrEn && (bus.addr == spiRegsPkg::regRiseFlags)) ?
                          bus.wrData : '0;

  // --------------------------------------------------------------------------
  // Read multiplexer
  // --------------------------------------------------------------------------

  always_comb begin
    case (bus.addr) inside
      spiRegsPkg::regOutData: begin
        bus.rdData = outReg;
      end
      spiRegsPkg::regDir: begin
        bus.rdData = dirReg;
      end
      spiRegsPkg::regPinIn: begin
        bus.rdData = gpio.pinIn;
      end
      spiRegsPkg::regRiseFlags: begin
        bus.rdData = gpio.riseFlags;
      end
      [spiRegsPkg::regScratchFirst:spiRegsPkg::regScratchLast]: begin
        bus.rdData = scratch[scratchSel];
      end
      // Unmapped indexes read zero
      default: begin
        bus.rdData = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Port control
  // --------------------------------------------------------------------------

  assign gpio.outData = outReg;
  assign gpio.dirData = dirReg;

endmodule

//--- hdl/gpioPort.sv
// GPIO port block; samples pins on SCK, keeps sticky rise flags and drives pin outputs
`timescale 1ns/100ps

module gpioPort (
  input  logic SCK,
  input  spiRegsPkg::byteT gpioIn,
  output spiRegsPkg::byteT gpioOut,
  output spiRegsPkg::byteT gpioOe,
  gpioCtrlIf.port gpio
);

  // --------------------------------------------------------------------------
  // Pin sampling
  // --------------------------------------------------------------------------

  // Current and previous samples
  spiRegsPkg::byteT pinSample;
  spiRegsPkg::byteT pinPrev;
  // Sticky flags and this edge's rises
  spiRegsPkg::byteT riseFlags;
  spiRegsPkg::byteT riseNow;

  // Edges only seen while SCK toggles
  always_ff @(posedge SCK) begin
    pinSample <= gpioIn;
    pinPrev <= pinSample;
  end

  // --------------------------------------------------------------------------
  // Rising-edge flags
  // --------------------------------------------------------------------------

  // Sampled pin went from 0 to 1 on the last edge
  assign riseNow = pinSample & ~pinPrev;

  // Set wins over a clear on the same edge
  always_ff @(posedge SCK) begin
    riseFlags <= (riseFlags & ~gpio.clearMask) | riseNow;
  end

  assign gpio.pinIn = pinSample;
  assign gpio.riseFlags = riseFlags;

  // --------------------------------------------------------------------------
  // Pin drive
  // --------------------------------------------------------------------------

  // Output latch and enables straight from the bank
  assign gpioOut = gpio.outData;
  assign gpioOe = gpio.dirData;

endmodule

//--- hdl/spiGpioTop.sv
// Top level of the serial GPIO slave; connects decoder, register bank and port to the pins
`timescale 1ns/100ps

module spiGpioTop (
  // Serial host side
  input  logic SCK,
  input  logic CS,
  input  logic SI,
  output logic SO,
  output logic soEnable,
  // General-purpose port
  input  spiRegsPkg::byteT gpioIn,
  output spiRegsPkg::byteT gpioOut,
  output spiRegsPkg::byteT gpioOe
);

  // --------------------------------------------------------------------------
  // Internal buses
  // --------------------------------------------------------------------------

  // Decoder to bank
  regAccessIf regBus ();
  // Bank to port block
  gpioCtrlIf gpioBus ();

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------

  // Frame logic, the only part cleared by CS
  spiFrameDecoder u_frameDecoder (
    .SCK      (SCK),
    .CS       (CS),
    .SI       (SI),
    .SO       (SO),
    .soEnable (soEnable),
    .bus      (regBus.decoder)
  );

  // Register storage and readback
  regBank u_regBank (
    .SCK  (SCK),
    .bus  (regBus.bank),
    .gpio (gpioBus.bank)
  );

  // Pin sampling and drive
  gpioPort u_gpioPort (
    .SCK     (SCK),
    .gpioIn  (gpioIn),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe),
    .gpio    (gpioBus.port)
  );

endmodule

//--- verif/spiGpioTb.sv
// Trace-driven testbench for the serial GPIO slave; run with tb.f, top module spiGpioTb
`timescale 1ns/100ps

module spiGpioTb;

  // --------------------------------------------------------------------------
  // Trace layout and run budget
  // --------------------------------------------------------------------------

  // Seven hex bytes per trace line
  localparam int traceCols = 7;
  localparam int maxLines = 64;
  localparam int cyclesPerLine = 20;
  localparam int cycleMargin = 50;

  // Trace operations
  localparam logic [7:0] opSetupWrite = 8'h00;
  localparam logic [7:0] opWrite = 8'h01;
  localparam logic [7:0] opRead = 8'h02;
  localparam logic [7:0] opPins = 8'h03;
  localparam logic [7:0] opWriteRead = 8'h04;
  // Unused slots keep this after the fill
  localparam logic [7:0] opEnd = 8'hFF;

  logic SCK = 1'b0;
  logic CS;
  logic SI;
  logic SO;
  logic soEnable;
  spiRegsPkg::byteT gpioIn;
  spiRegsPkg::byteT gpioOut;
  spiRegsPkg::byteT gpioOe;

  spiRegsPkg::byteT traceMem [traceCols*maxLines];
  int lineCount = 0;
  int cycleLimit = 0;
  int cycleCount = 0;

  spiGpioTop u_spiGpioTop (
    .SCK      (SCK),
    .CS       (CS),
    .SI       (SI),
    .SO       (SO),
    .soEnable (soEnable),
    .gpioIn   (gpioIn),
    .gpioOut  (gpioOut),
    .gpioOe   (gpioOe)
  );

  // --------------------------------------------------------------------------
  // Clock and timeout
  // --------------------------------------------------------------------------

  // 40 ns period
  always #20 SCK = ~SCK;

  // Limit only armed once the trace length is known
  always @(posedge SCK) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout: trace not finished within %0d SCK cycles", cycleLimit);
      reportFailure();
    end
  end

  // --------------------------------------------------------------------------
  // Host helpers
  // --------------------------------------------------------------------------

  task automatic reportFailure();
    $display("Verification failed");
    $fatal(1);
  endtask

  // Read flag on top, bit 6 left at zero
  function automatic spiRegsPkg::byteT addressByte(input logic isRead,
                                                   input spiRegsPkg::regIdxT idx);
    return {isRead, 1'b0, idx};
  endfunction

  // CS low, SO must stay disabled
  task automatic idleCycles(input int count);
    CS = 1'b0;
    SI = 1'b0;
    repeat (count) begin
      @(negedge SCK);
      assert (soEnable === 1'b0) else begin
        $display("error soEnable idle got 0x%h exp 0x0", soEnable);
        reportFailure();
      end
    end
  endtask

  // Starts on a falling edge and ends on the falling edge after edge 16
  task automatic runFrame(input spiRegsPkg::byteT addrByte, input spiRegsPkg::byteT dataByte,
                          output spiRegsPkg::byteT soByte);
    logic [15:0] bits;
    logic isRead;
    logic expEnable;
    bits = {addrByte, dataByte};
    isRead = addrByte[spiRegsPkg::readFlagBit];
    soByte = '0;
    CS = 1'b1;
    for (int edgeNum = 1; edgeNum <= spiRegsPkg::frameBits; edgeNum++) begin
      // MSB first
      SI = bits[spiRegsPkg::frameBits - edgeNum];
      @(negedge SCK);
      // One read bit per edge from edge 9
      if (edgeNum > spiRegsPkg::addrBits) begin
        soByte = {soByte[6:0], SO};
      end
      // Enabled from edge 8 until the frame ends
      expEnable = isRead && (edgeNum >= spiRegsPkg::addrBits) &&
                  (edgeNum < spiRegsPkg::frameBits);
      assert (soEnable === expEnable) else begin
        $display("error soEnable edge %0d got 0x%h exp 0x%h", edgeNum, soEnable, expEnable);
        reportFailure();
      end
    end
  endtask

  task automatic writeReg(input spiRegsPkg::regIdxT idx, input spiRegsPkg::byteT data);
    spiRegsPkg::byteT unused;
    runFrame(addressByte(1'b0, idx), data, unused);
    // CS stays high through edge 17, the commit edge
    @(negedge SCK);
    idleCycles(2);
  endtask

  task automatic readReg(input spiRegsPkg::regIdxT idx, output spiRegsPkg::byteT value);
    runFrame(addressByte(1'b1, idx), 8'h00, value);
    idleCycles(2);
  endtask

  // Second frame starts on edge 17 with CS still high
  task automatic writeThenRead(input spiRegsPkg::regIdxT idx, input spiRegsPkg::byteT data,
                               output spiRegsPkg::byteT value);
    spiRegsPkg::byteT unused;
    runFrame(addressByte(1'b0, idx), data, unused);
    runFrame(addressByte(1'b1, idx), 8'h00, value);
    idleCycles(2);
  endtask

  task automatic checkRead(input spiRegsPkg::regIdxT idx, input spiRegsPkg::byteT got,
                           input spiRegsPkg::byteT exp);
    assert (got === exp) else begin
      $display("error SO read idx 0x%h got 0x%h exp 0x%h", idx, got, exp);
      reportFailure();
    end
  endtask

  task automatic checkPort(input int line, input spiRegsPkg::byteT expOut,
                           input spiRegsPkg::byteT expOe);
    assert (gpioOut === expOut) else begin
      $display("error gpioOut line %0d got 0x%h exp 0x%h", line, gpioOut, expOut);
      reportFailure();
    end
    assert (gpioOe === expOe) else begin
      $display("error gpioOe line %0d got 0x%h exp 0x%h", line, gpioOe, expOe);
      reportFailure();
    end
  endtask

  // --------------------------------------------------------------------------
  // Trace runner
  // --------------------------------------------------------------------------

  initial begin
    logic [7:0] op;
    spiRegsPkg::regIdxT idx;
    spiRegsPkg::byteT data;
    spiRegsPkg::byteT pins;
    spiRegsPkg::byteT expOut;
    spiRegsPkg::byteT expOe;
    spiRegsPkg::byteT expRd;
    spiRegsPkg::byteT got;
    int base;
    CS = 1'b0;
    SI = 1'b0;
    gpioIn = '0;
    for (int i = 0; i < traceCols*maxLines; i++) begin
      traceMem[i] = opEnd;
    end
    $readmemh("verif/spiGpioTrace.txt", traceMem);
    while (lineCount < maxLines && traceMem[lineCount*traceCols] !== opEnd) begin
      lineCount++;
    end
    cycleLimit = cyclesPerLine*lineCount + cycleMargin;

    // Reset, three cycles with CS low
    idleCycles(3);

    for (int line = 0; line < lineCount; line++) begin
      base = line*traceCols;
      op = traceMem[base];
      idx = spiRegsPkg::regIdxT'(traceMem[base+1]);
      data = traceMem[base+2];
      pins = traceMem[base+3];
      expOut = traceMem[base+4];
      expOe = traceMem[base+5];
      expRd = traceMem[base+6];
      // Pins column repeats the current value on every line
      gpioIn = pins;
      case (op)
        opSetupWrite, opWrite: begin
          writeReg(idx, data);
        end
        opRead: begin
          readReg(idx, got);
          checkRead(idx, got, expRd);
        end
        opPins: begin
          // Held long enough for sample and edge flag
          idleCycles(3);
        end
        opWriteRead: begin
          writeThenRead(idx, data, got);
          checkRead(idx, got, expRd);
        end
        default: begin
          $display("Unknown operation 0x%h on trace line %0d", op, line);
          reportFailure();
        end
      endcase
      // Port outputs undefined until both registers written
      if (op != opSetupWrite) begin
        checkPort(line, expOut, expOe);
      end
    end

    if (lineCount > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Trace file held no lines to run");
      reportFailure();
    end
  end

endmodule

//--- verif/spiGpioTrace.txt
// Columns in hex: op idx data pins expOut expOe expRead
// Ops: 0 setup write, 1 write, 2 read, 3 set pins, 4 write then read in one CS window
00 00 A5 00 00 00 00
01 01 3C 00 A5 3C 00
01 03 FF 00 A5 3C 00
01 00 5A 00 5A 3C 00
02 00 00 00 5A 3C 5A
02 01 00 00 5A 3C 3C
01 04 11 00 5A 3C 00
01 05 22 00 5A 3C 00
01 06 33 00 5A 3C 00
01 07 44 00 5A 3C 00
02 04 00 00 5A 3C 11
02 07 00 00 5A 3C 44
02 09 00 00 5A 3C 00
02 03 00 00 5A 3C 00
03 00 00 96 5A 3C 00
02 02 00 96 5A 3C 96
01 02 FF 96 5A 3C 00
02 02 00 96 5A 3C 96
02 03 00 96 5A 3C 96
03 00 00 00 5A 3C 00
02 03 00 00 5A 3C 96
01 03 82 00 5A 3C 00
02 03 00 00 5A 3C 14
03 00 00 01 5A 3C 00
02 03 00 01 5A 3C 15
04 05 77 01 5A 3C 77
04 00 C3 01 C3 3C C3

//--- tb.f
hdl/spiRegsPkg.sv
hdl/regAccessIf.sv
hdl/gpioCtrlIf.sv
hdl/spiFrameDecoder.sv
hdl/regBank.sv
hdl/gpioPort.sv
hdl/spiGpioTop.sv
verif/spiGpioTb.sv

//--- Bender.yml
package:
  name: spi_gpio

sources:
  # Design, in compile order
  - hdl/spiRegsPkg.sv
  - hdl/regAccessIf.sv
  - hdl/gpioCtrlIf.sv
  - hdl/spiFrameDecoder.sv
  - hdl/regBank.sv
  - hdl/gpioPort.sv
  - hdl/spiGpioTop.sv
  # Testbench
  - target: test
    files:
      - verif/spiGpioTb.sv
